// ==== sim.f ====
rtl/gfxTypes.sv
rtl/vramBus.sv
rtl/tileMemory.sv
rtl/backgroundMaps.sv
rtl/scanlineRenderer.sv
rtl/whizGraphics.sv
tests/whizGraphicsTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator, runs it and looks for the pass line.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
   --top-module whizGraphicsTb -o whizGraphicsSim \
   && ./obj_dir/whizGraphicsSim | tee /dev/stderr | grep -qx "TB PASSED" \
   && echo "simulation passed" \
   || { echo "simulation failed"; exit 1; }

// ==== tests/whizGraphicsTb.sv ====
`timescale 1ns/1ps

module whizGraphicsTb;

   localparam int ResetCycles = 8;
   localparam int RoundTrips  = 300;
   localparam int LoadCycles  = gfxTypes::TileSize + 2 * gfxTypes::MapSize;
   localparam int LineBudget  = gfxTypes::LineWidth + 10;
   // three bus cycles per round trip and one frame plus one line, doubled for margin.
   localparam int CycleLimit  = 2 * (ResetCycles + LoadCycles + RoundTrips * 4 +
                                     (gfxTypes::LineCount + 1) * LineBudget);

   logic                db;
   logic                reset;
   gfxTypes::busRequest cpuBus;
   gfxTypes::busData    readData;
   logic                readValid;
   logic                drawLine;
   gfxTypes::pixelOut   pixels;
   logic                renderComplete;

   gfxTypes::busData tileShadow [gfxTypes::TileSize];
   gfxTypes::busData mapShadow [2 * gfxTypes::MapSize]; // second map from entry 1024 on.
   gfxTypes::lcdRegs regShadow;
   logic [31:0]      lfsrState;
   int               errorCount;
   int               cycleCount;
   int               nextLine;

   whizGraphics whizGraphics_inst (
      .db(db),
      .reset(reset),
      .cpuBus(cpuBus),
      .readData(readData),
      .readValid(readValid),
      .drawLine(drawLine),
      .pixels(pixels),
      .renderComplete(renderComplete)
   );

   initial begin
      db = 1'b0;
      forever #10 db = ~db;
   end

   initial begin
      cycleCount = 0;
      while (cycleCount < CycleLimit) begin
         @(posedge db);
         cycleCount++;
      end
      $display("timeout: the run did not finish within %0d cycles", CycleLimit);
      $display("TB FAILED");
      $finish;
   end

   // taps for x^32 + x^22 + x^2 + x + 1, one step per bit taken.
   function automatic logic [31:0] randomBits(input int count);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < count; i++) begin
         lfsrState = {lfsrState[30:0],
                      lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
         value = {value[30:0], lfsrState[0]};
      end
      return value;
   endfunction

   task automatic checkValue(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
      if (actual !== expected) begin
         errorCount++;
         $display("FAILED %0t: %s is %0h, expected %0h", $time, what, actual, expected);
      end
   endtask

   function automatic gfxTypes::busData expectedRead(input gfxTypes::busAddr addr);
      int tileOffset;
      int mapOffset;
      tileOffset = int'(addr) - int'(gfxTypes::TileBase);
      mapOffset = int'(addr) - int'(gfxTypes::Map1Base);
      if (tileOffset >= 0 && tileOffset < gfxTypes::TileSize) return tileShadow[tileOffset];
      if (mapOffset >= 0 && mapOffset < 2 * gfxTypes::MapSize) return mapShadow[mapOffset];
      case (addr)
         gfxTypes::LcdcAddr:    return regShadow.control;
         gfxTypes::ScrollYAddr: return regShadow.scrollY;
         gfxTypes::ScrollXAddr: return regShadow.scrollX;
         gfxTypes::PaletteAddr: return regShadow.palette;
         default:               return 8'hFF;
      endcase
   endfunction

   function automatic void shadowWrite(input gfxTypes::busAddr addr,
                                       input gfxTypes::busData data);
      int tileOffset;
      int mapOffset;
      tileOffset = int'(addr) - int'(gfxTypes::TileBase);
      mapOffset = int'(addr) - int'(gfxTypes::Map1Base);
      if (tileOffset >= 0 && tileOffset < gfxTypes::TileSize) begin
         tileShadow[tileOffset] = data;
      end else if (mapOffset >= 0 && mapOffset < 2 * gfxTypes::MapSize) begin
         mapShadow[mapOffset] = data;
      end else if (addr == gfxTypes::LcdcAddr) begin
         regShadow.control = data;
      end else if (addr == gfxTypes::ScrollYAddr) begin
         regShadow.scrollY = data;
      end else if (addr == gfxTypes::ScrollXAddr) begin
         regShadow.scrollX = data;
      end else if (addr == gfxTypes::PaletteAddr) begin
         regShadow.palette = data;
      end
   endfunction

   function automatic gfxTypes::shade expectedShade(input int x, input int line);
      logic [7:0]       bgX;
      logic [7:0]       bgY;
      int               mapEntry;
      int               rowOffset;
      int               bitPos;
      gfxTypes::busData lowPlane;
      gfxTypes::busData highPlane;
      logic [1:0]       colorNum;
      bgX = 8'(int'(regShadow.scrollX) + x);
      bgY = 8'(int'(regShadow.scrollY) + line);
      mapEntry = (regShadow.control[3] ? gfxTypes::MapSize : 0) +
                 int'(bgY / 8) * 32 + int'(bgX / 8);
      rowOffset = int'(mapShadow[mapEntry]) * 16 + int'(bgY % 8) * 2;
      lowPlane = tileShadow[rowOffset];
      highPlane = tileShadow[rowOffset + 1];
      bitPos = 7 - int'(bgX % 8);
      colorNum = {highPlane[bitPos], lowPlane[bitPos]};
      return regShadow.palette[2 * colorNum +: 2];
   endfunction

   // the write stays on the bus until the next task drives it.
   task automatic busWrite(input gfxTypes::busAddr addr, input gfxTypes::busData data);
      @(negedge db);
      cpuBus = '{read: 1'b0, write: 1'b1, addr: addr, wdata: data};
      shadowWrite(addr, data);
   endtask

   task automatic readAndCheck(input gfxTypes::busAddr addr);
      gfxTypes::busData expected;
      expected = expectedRead(addr);
      @(negedge db);
      cpuBus = '{read: 1'b1, write: 1'b0, addr: addr, wdata: 8'h00};
      @(negedge db);
      checkValue(32'(readValid), 32'd1, $sformatf("readValid for %h", addr));
      checkValue(32'(readData), 32'(expected), $sformatf("read data at %h", addr));
      cpuBus = '0;
   endtask

   task automatic renderLine(input bit strayPulse);
      int waited;
      int line;
      line = nextLine;
      @(negedge db);
      cpuBus = '0;
      drawLine = 1'b1;
      @(negedge db);
      drawLine = 1'b0;
      waited = 0;
      while (!pixels.valid && waited < 8) begin
         @(negedge db);
         waited++;
      end
      if (!pixels.valid) begin
         errorCount++;
         $display("no pixel came out after drawLine for line %0d", line);
         return;
      end
      checkValue(32'(waited), 32'd3, "cycles from drawLine to the first pixel");
      for (int x = 0; x < gfxTypes::LineWidth; x++) begin
         checkValue(32'(pixels.valid), 32'd1, $sformatf("valid at x %0d", x));
         checkValue(32'(pixels.x), 32'(x), "pixel x");
         checkValue(32'(pixels.line), 32'(line), "pixel line");
         checkValue(32'(pixels.value), 32'(expectedShade(x, line)),
                    $sformatf("shade at x %0d line %0d", x, line));
         checkValue(32'(renderComplete),
                    32'(x == gfxTypes::LineWidth - 1 && line == gfxTypes::LineCount - 1),
                    $sformatf("renderComplete at x %0d line %0d", x, line));
         @(negedge db);
         drawLine = strayPulse && x == 40; // lands while the line is running.
      end
      checkValue(32'(pixels.valid), 32'd0, "valid after the line");
      checkValue(32'(renderComplete), 32'd0, "renderComplete after the line");
      nextLine = (line + 1) % gfxTypes::LineCount;
   endtask

   initial begin
      gfxTypes::busAddr addr;
      logic [1:0]       region;
      lfsrState = 32'h7b5b;
      errorCount = 0;
      nextLine = 0;
      reset = 1'b1;
      drawLine = 1'b0;
      cpuBus = '0;
      regShadow = '{control: 8'h00, scrollY: 8'h00, scrollX: 8'h00, palette: 8'hE4};
      repeat (ResetCycles) @(negedge db);
      reset = 1'b0;

      checkValue(32'(pixels.valid), 32'd0, "valid after reset");
      checkValue(32'(renderComplete), 32'd0, "renderComplete after reset");
      checkValue(32'(readValid), 32'd0, "readValid after reset");
      readAndCheck(gfxTypes::PaletteAddr);

      for (int i = 0; i < RoundTrips; i++) begin
         region = 2'(randomBits(2));
         case (region)
            2'd0: addr = gfxTypes::TileBase + 16'(randomBits(13) % gfxTypes::TileSize);
            2'd1: addr = gfxTypes::Map1Base + 16'(randomBits(11));
            2'd2: begin
               case (2'(randomBits(2)))
                  2'd0:    addr = gfxTypes::LcdcAddr;
                  2'd1:    addr = gfxTypes::ScrollYAddr;
                  2'd2:    addr = gfxTypes::ScrollXAddr;
                  default: addr = gfxTypes::PaletteAddr;
               endcase
            end
            default: begin
               if (randomBits(1) == 32'd1) begin
                  addr = {8'hFF, 8'(randomBits(8))}; // unused registers and holes.
               end else begin
                  addr = {4'hA, 12'(randomBits(12))};
               end
            end
         endcase
         busWrite(addr, 8'(randomBits(8)));
         readAndCheck(addr);
      end

      for (int a = 0; a < gfxTypes::TileSize; a++) begin
         busWrite(gfxTypes::TileBase + 16'(a), 8'(randomBits(8)));
      end
      for (int a = 0; a < 2 * gfxTypes::MapSize; a++) begin
         busWrite(gfxTypes::Map1Base + 16'(a), 8'(randomBits(8)));
      end
      busWrite(gfxTypes::LcdcAddr, 8'h00);
      busWrite(gfxTypes::ScrollXAddr, 8'h00);
      busWrite(gfxTypes::ScrollYAddr, 8'h00);
      busWrite(gfxTypes::PaletteAddr, 8'(randomBits(8)));
      repeat (4) renderLine(1'b0);

      // control bit 3 alternates so both maps are drawn, the last line wraps both ways.
      for (int n = 0; n < 8; n++) begin
         busWrite(gfxTypes::ScrollXAddr, (n == 7) ? 8'hF8 : 8'(randomBits(8)));
         busWrite(gfxTypes::ScrollYAddr, (n == 7) ? 8'hFF : 8'(randomBits(8)));
         busWrite(gfxTypes::LcdcAddr, {4'(randomBits(4)), n[0], 3'(randomBits(3))});
         busWrite(gfxTypes::PaletteAddr, 8'(randomBits(8)));
         renderLine(1'b0);
      end

      while (nextLine != 0) begin
         renderLine(1'b1);
      end
      renderLine(1'b1);

      $display("run complete: %0d errors", errorCount);
      if (errorCount == 0) begin
         $display("TB PASSED");
      end else begin
         $display("TB FAILED");
      end
      $finish;
   end

endmodule

// ==== rtl/whizGraphics.sv ====
`timescale 1ns/1ps

module whizGraphics (
   input  logic                db,
   input  logic                reset,
   input  gfxTypes::busRequest cpuBus,
   output gfxTypes::busData    readData,
   output logic                readValid,
   input  logic                drawLine,
   output gfxTypes::pixelOut   pixels,
   output logic                renderComplete
);

   gfxTypes::lcdRegs   regs;
   logic               mapSelect;
   logic               tileWrite;
   logic               mapWrite;
   gfxTypes::tileAddr  cpuTileAddr;
   logic [10:0]        cpuMapAddr;
   gfxTypes::busData   wdata;
   gfxTypes::busData   tileCpuData;
   gfxTypes::busData   mapCpuData;
   gfxTypes::mapAddr   mapRdAddr;
   gfxTypes::tileIndex mapRdData;
   logic [11:0]        tileRdAddr;
   gfxTypes::tileRow   tileRdData;

   vramBus vramBus_inst (
      .db(db),
      .reset(reset),
      .cpuBus(cpuBus),
      .readData(readData),
      .readValid(readValid),
      .regs(regs),
      .mapSelect(mapSelect),
      .tileWrite(tileWrite),
      .mapWrite(mapWrite),
      .cpuTileAddr(cpuTileAddr),
      .cpuMapAddr(cpuMapAddr),
      .wdata(wdata),
      .tileCpuData(tileCpuData),
      .mapCpuData(mapCpuData)
   );

   tileMemory tileMemory_inst (
      .db(db),
      .cpuWrite(tileWrite),
      .cpuAddr(cpuTileAddr),
      .cpuWdata(wdata),
      .cpuRdata(tileCpuData),
      .rdAddr(tileRdAddr),
      .rdData(tileRdData)
   );

   backgroundMaps backgroundMaps_inst (
      .db(db),
      .cpuWrite(mapWrite),
      .cpuAddr(cpuMapAddr),
      .cpuWdata(wdata),
      .cpuRdata(mapCpuData),
      .mapSelect(mapSelect),
      .rdAddr(mapRdAddr),
      .rdData(mapRdData)
   );

   scanlineRenderer scanlineRenderer_inst (
      .db(db),
      .reset(reset),
      .drawLine(drawLine),
      .regs(regs),
      .mapRdAddr(mapRdAddr),
      .mapRdData(mapRdData),
      .tileRdAddr(tileRdAddr),
      .tileRdData(tileRdData),
      .pixels(pixels),
      .renderComplete(renderComplete)
   );

endmodule

// ==== rtl/scanlineRenderer.sv ====
`timescale 1ns/1ps

module scanlineRenderer (
   input  logic               db,
   input  logic               reset,
   input  logic               drawLine,
   input  gfxTypes::lcdRegs   regs,
   output gfxTypes::mapAddr   mapRdAddr,
   input  gfxTypes::tileIndex mapRdData,
   output logic [11:0]        tileRdAddr,
   input  gfxTypes::tileRow   tileRdData,
   output gfxTypes::pixelOut  pixels,
   output logic               renderComplete
);

   // what a pixel carries alongside the memory reads.
   typedef struct packed {
      logic                valid;
      gfxTypes::pixelX     x;
      gfxTypes::lineNum    line;
      gfxTypes::fineOffset fineX;
      gfxTypes::busData    palette;
   } pixelTag;

   gfxTypes::renderState state;
   gfxTypes::pixelX      xCount;
   gfxTypes::lineNum     lineCount;
   logic [7:0]           bgX;
   logic [7:0]           bgY;
   logic                 issue;
   logic                 lastIssue;
   pixelTag              s1Tag;
   pixelTag              s2Tag;
   gfxTypes::fineOffset  s1FineY;
   logic [1:0]           color;

   assign issue = state == gfxTypes::Running;
   assign lastIssue = issue && xCount == gfxTypes::pixelX'(gfxTypes::LineWidth - 1);

   assign bgX = regs.scrollX + xCount; // wraps at 256 by width.
   assign bgY = regs.scrollY + lineCount;
   assign mapRdAddr = {bgY[7:3], bgX[7:3]};

   // row address is index times 8 plus the fine Y offset.
   assign tileRdAddr = {1'b0, mapRdData, s1FineY};

   // bit 7 - fineX of each plane, high plane gives the upper bit.
   assign color = {tileRdData[{1'b1, ~s2Tag.fineX}], tileRdData[{1'b0, ~s2Tag.fineX}]};

   always_ff @(posedge db) begin
      if (reset) begin
         state <= gfxTypes::Idle;
         xCount <= '0;
         lineCount <= '0;
      end else begin
         case (state)
            gfxTypes::Idle: begin
               if (drawLine) begin
                  state <= gfxTypes::Running;
                  xCount <= '0;
               end
            end
            default: begin
               if (lastIssue) begin
                  state <= gfxTypes::Idle;
                  if (lineCount == gfxTypes::lineNum'(gfxTypes::LineCount - 1)) begin
                     lineCount <= '0;
                  end else begin
                     lineCount <= lineCount + 1'b1;
                  end
               end else begin
                  xCount <= xCount + 1'b1;
               end
            end
         endcase
      end
   end

   always_ff @(posedge db) begin
      s1FineY <= bgY[2:0];
   end

   always_ff @(posedge db) begin
      if (reset) begin
         s1Tag <= '0;
         s2Tag <= '0;
         pixels <= '0;
         renderComplete <= 1'b0;
      end else begin
         s1Tag <= '{valid: issue, x: xCount, line: lineCount, fineX: bgX[2:0],
                    palette: regs.palette};
         s2Tag <= s1Tag;
         pixels.valid <= s2Tag.valid;
         pixels.x <= s2Tag.x;
         pixels.line <= s2Tag.line;
         pixels.value <= s2Tag.palette[{color, 1'b0} +: 2];
         renderComplete <= s2Tag.valid &&
                           s2Tag.x == gfxTypes::pixelX'(gfxTypes::LineWidth - 1) &&
                           s2Tag.line == gfxTypes::lineNum'(gfxTypes::LineCount - 1);
      end
   end

   assert property (@(posedge db) disable iff (reset)
      pixels.valid |-> pixels.x < gfxTypes::pixelX'(gfxTypes::LineWidth));

endmodule

// ==== rtl/backgroundMaps.sv ====
`timescale 1ns/1ps

module backgroundMaps (
   input  logic               db,
   input  logic               cpuWrite,
   input  logic [10:0]        cpuAddr,
   input  gfxTypes::busData   cpuWdata,
   output gfxTypes::busData   cpuRdata,
   input  logic               mapSelect,
   input  gfxTypes::mapAddr   rdAddr,
   output gfxTypes::tileIndex rdData
);

   gfxTypes::tileIndex maps [2][gfxTypes::MapSize];

   logic             cpuMap;
   gfxTypes::mapAddr cpuEntry;

   assign cpuMap = cpuAddr[10]; // set for the map at 9C00h.
   assign cpuEntry = cpuAddr[9:0];

   always_ff @(posedge db) begin
      if (cpuWrite) begin
         maps[cpuMap][cpuEntry] <= cpuWdata;
      end
   end

   always_ff @(posedge db) begin
      cpuRdata <= maps[cpuMap][cpuEntry];
   end

   // the render port only ever sees the map chosen by the control register.
   always_ff @(posedge db) begin
      rdData <= maps[mapSelect][rdAddr];
   end

endmodule

// ==== rtl/tileMemory.sv ====
`timescale 1ns/1ps

module tileMemory (
   input  logic              db,
   input  logic              cpuWrite,
   input  gfxTypes::tileAddr cpuAddr,
   input  gfxTypes::busData  cpuWdata,
   output gfxTypes::busData  cpuRdata,
   input  logic [11:0]       rdAddr,
   output gfxTypes::tileRow  rdData
);

   // even bytes hold the low plane and odd bytes the high plane of each row.
   gfxTypes::busData evenBank [gfxTypes::TileBankDepth];
   gfxTypes::busData oddBank  [gfxTypes::TileBankDepth];

   logic [11:0] cpuRow;
   logic        cpuOdd;

   assign cpuRow = cpuAddr[12:1];
   assign cpuOdd = cpuAddr[0];

   always_ff @(posedge db) begin
      if (cpuWrite && !cpuOdd) begin
         evenBank[cpuRow] <= cpuWdata;
      end
   end

   always_ff @(posedge db) begin
      if (cpuWrite && cpuOdd) begin
         oddBank[cpuRow] <= cpuWdata;
      end
   end

   always_ff @(posedge db) begin
      if (cpuOdd) begin
         cpuRdata <= oddBank[cpuRow];
      end else begin
         cpuRdata <= evenBank[cpuRow];
      end
   end

   always_ff @(posedge db) begin
      rdData <= {oddBank[rdAddr], evenBank[rdAddr]}; // both planes in one access.
   end

   assert property (@(posedge db)
      cpuWrite |-> cpuAddr < gfxTypes::tileAddr'(gfxTypes::TileSize));

endmodule

// ==== rtl/vramBus.sv ====
`timescale 1ns/1ps

module vramBus (
   input  logic                db,
   input  logic                reset,
   input  gfxTypes::busRequest cpuBus,
   output gfxTypes::busData    readData,
   output logic                readValid,
   output gfxTypes::lcdRegs    regs,
   output logic                mapSelect,
   output logic                tileWrite,
   output logic                mapWrite,
   output gfxTypes::tileAddr   cpuTileAddr,
   output logic [10:0]         cpuMapAddr,
   output gfxTypes::busData    wdata,
   input  gfxTypes::busData    tileCpuData,
   input  gfxTypes::busData    mapCpuData
);

   gfxTypes::regionCode region;
   gfxTypes::regionCode readRegion;
   gfxTypes::busAddr    tileOffset;
   gfxTypes::busAddr    mapOffset;
   gfxTypes::busData    regReadByte;
   gfxTypes::busData    heldByte;

   always_comb begin
      region = gfxTypes::RegionNone;
      regReadByte = 8'hFF; // unused registers and holes read as all ones.
      if (cpuBus.addr >= gfxTypes::TileBase &&
          cpuBus.addr < gfxTypes::TileBase + gfxTypes::busAddr'(gfxTypes::TileSize)) begin
         region = gfxTypes::RegionTile;
      end else if (cpuBus.addr >= gfxTypes::Map1Base &&
                   cpuBus.addr < gfxTypes::Map2Base + gfxTypes::busAddr'(gfxTypes::MapSize)) begin
         region = gfxTypes::RegionMap;
      end else begin
         case (cpuBus.addr)
            gfxTypes::LcdcAddr: begin
               region = gfxTypes::RegionReg;
               regReadByte = regs.control;
            end
            gfxTypes::ScrollYAddr: begin
               region = gfxTypes::RegionReg;
               regReadByte = regs.scrollY;
            end
            gfxTypes::ScrollXAddr: begin
               region = gfxTypes::RegionReg;
               regReadByte = regs.scrollX;
            end
            gfxTypes::PaletteAddr: begin
               region = gfxTypes::RegionReg;
               regReadByte = regs.palette;
            end
            default: region = gfxTypes::RegionNone;
         endcase
      end
   end

   assign tileOffset = cpuBus.addr - gfxTypes::TileBase;
   assign mapOffset = cpuBus.addr - gfxTypes::Map1Base; // bit 10 picks the second map.
   assign cpuTileAddr = tileOffset[12:0];
   assign cpuMapAddr = mapOffset[10:0];
   assign wdata = cpuBus.wdata;
   assign tileWrite = cpuBus.write && region == gfxTypes::RegionTile;
   assign mapWrite = cpuBus.write && region == gfxTypes::RegionMap;
   assign mapSelect = regs.control[3];

   always_ff @(posedge db) begin
      if (reset) begin
         regs <= '{control: '0, scrollY: '0, scrollX: '0, palette: gfxTypes::PaletteReset};
      end else if (cpuBus.write && region == gfxTypes::RegionReg) begin
         case (cpuBus.addr)
            gfxTypes::LcdcAddr:    regs.control <= cpuBus.wdata;
            gfxTypes::ScrollYAddr: regs.scrollY <= cpuBus.wdata;
            gfxTypes::ScrollXAddr: regs.scrollX <= cpuBus.wdata;
            default:               regs.palette <= cpuBus.wdata;
         endcase
      end
   end

   always_ff @(posedge db) begin
      if (reset) begin
         readValid <= 1'b0;
         readRegion <= gfxTypes::RegionNone;
      end else begin
         readValid <= cpuBus.read;
         readRegion <= region;
      end
   end

   always_ff @(posedge db) begin
      if (cpuBus.read) begin
         heldByte <= regReadByte;
      end
   end

   // memory replies come straight from the synchronous read ports.
   always_comb begin
      case (readRegion)
         gfxTypes::RegionTile: readData = tileCpuData;
         gfxTypes::RegionMap:  readData = mapCpuData;
         default:              readData = heldByte;
      endcase
   end

   assert property (@(posedge db) disable iff (reset) !(cpuBus.read && cpuBus.write));

endmodule

// ==== rtl/gfxTypes.sv ====
package gfxTypes;

   typedef logic [15:0] busAddr;
   typedef logic [7:0]  busData;
   typedef logic [7:0]  tileIndex;
   typedef logic [12:0] tileAddr;
   typedef logic [9:0]  mapAddr;
   typedef logic [15:0] tileRow; // high plane in 15:8, low plane in 7:0.
   typedef logic [1:0]  shade;
   typedef logic [7:0]  pixelX;
   typedef logic [7:0]  lineNum;
   typedef logic [1:0]  regionCode;

   localparam busAddr LcdcAddr    = 16'hFF40;
   localparam busAddr ScrollYAddr = 16'hFF42;
   localparam busAddr ScrollXAddr = 16'hFF43;
   localparam busAddr PaletteAddr = 16'hFF47;

   localparam busAddr TileBase = 16'h8000;
   localparam int     TileSize = 6144;
   localparam int     TileBankDepth = TileSize / 2; // one row of one tile per entry pair.
   localparam busAddr Map1Base = 16'h9800;
   localparam busAddr Map2Base = 16'h9C00;
   localparam int     MapSize  = 1024;

   localparam int LineWidth = 160;
   localparam int LineCount = 144;
   localparam int TileDim   = 8;
   localparam int FineBits  = $clog2(TileDim);

   localparam busData PaletteReset = 8'hE4; // identity shading.

   // read region codes, kept for one cycle to steer the reply.
   localparam regionCode RegionNone = 2'd0;
   localparam regionCode RegionTile = 2'd1;
   localparam regionCode RegionMap  = 2'd2;
   localparam regionCode RegionReg  = 2'd3;

   typedef logic [FineBits-1:0] fineOffset;

   typedef struct packed {
      logic   read;
      logic   write;
      busAddr addr;
      busData wdata;
   } busRequest;

   typedef struct packed {
      busData control;
      busData scrollY;
      busData scrollX;
      busData palette;
   } lcdRegs;

   typedef struct packed {
      logic   valid;
      pixelX  x;
      lineNum line;
      shade   value;
   } pixelOut;

   typedef enum logic {
      Idle,
      Running
   } renderState;

endpackage
